//--- flist.f
+incdir+include
src/apb_pkg.sv
src/eeprom_pkg.sv
src/eeprom_apb_regs.sv
src/eeprom_sequencer.sv
src/i2c_bit_engine.sv
src/eeprom_ctrl_top.sv
tests/eeprom_model.sv
tests/tb_eeprom_ctrl.sv

//--- include/eeprom_params.svh
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// apb register offsets fit in 4 bits
`define APB_ADDR_W 4

// 2 Kbyte part, top 3 bits go to the select byte
`define EEPROM_ADDR_W 11

// CLK cycles per quarter of an SCL period
`define SCL_QDIV 4

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the EEPROM controller testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_eeprom_ctrl -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi

exit 0

//--- src/apb_pkg.sv
`default_nettype none
`include "eeprom_params.svh"

package apb_pkg;

    // host side request, sampled in the access phase
    typedef struct packed
    {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [31:0]            pwdata;
    } apb_req_t;

    typedef struct packed
    {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;  // refused command
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- src/eeprom_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_params.svh"

module eeprom_apb_regs
(
    input  wire                            CLK,
    input  wire                            RESET,
    input  wire apb_pkg::apb_req_t         apb_req,
    output apb_pkg::apb_rsp_t              apb_rsp,
    output logic                           xact_valid,
    output eeprom_pkg::eeprom_xact_t       xact,
    input  wire eeprom_pkg::xact_status_t  status
);

    localparam logic [`APB_ADDR_W-1:0] reg_cmd    = 'h0;
    localparam logic [`APB_ADDR_W-1:0] reg_wdata  = 'h4;
    localparam logic [`APB_ADDR_W-1:0] reg_rdata  = 'h8;
    localparam logic [`APB_ADDR_W-1:0] reg_status = 'hC;

    logic       acc_wr;
    logic       cmd_wr;
    logic       busy;
    logic [7:0] wdata_q;

    assign acc_wr = apb_req.psel && apb_req.penable && apb_req.pwrite;
    assign cmd_wr = acc_wr && apb_req.paddr == reg_cmd;

    // command handed over but not yet taken by the sequencer
    assign busy = status.busy || xact_valid;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            xact_valid <= 1'b0;
            wdata_q    <= 8'h00;
        end
        else
        begin
            xact_valid <= cmd_wr && !busy;
            if (acc_wr && apb_req.paddr == reg_wdata)
                wdata_q <= apb_req.pwdata[7:0];
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_wr && !busy)
        begin
            xact.rw    <= apb_req.pwdata[0];
            xact.addr  <= apb_req.pwdata[8 +: `EEPROM_ADDR_W];
            xact.wdata <= wdata_q;
        end
    end

    always_comb
    begin
        apb_rsp.prdata  = 32'h0;
        apb_rsp.pready  = 1'b1;  // no wait states
        apb_rsp.pslverr = cmd_wr && busy;
        if (apb_req.psel && !apb_req.pwrite)
        begin
            case (apb_req.paddr)
                reg_wdata:
                    apb_rsp.prdata = {24'h0, wdata_q};
                reg_rdata:
                    apb_rsp.prdata = {24'h0, status.rdata};
                reg_status:
                begin
                    // old done/nack are stale once a command is queued
                    apb_rsp.prdata = {29'h0,
                                      status.nack && !xact_valid,
                                      status.done && !xact_valid,
                                      busy};
                end
                default:
                    apb_rsp.prdata = 32'h0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/eeprom_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_ctrl_top
(
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire apb_pkg::apb_req_t  apb_req,
    output apb_pkg::apb_rsp_t       apb_rsp,
    output logic                    scl,
    output logic                    sda_oe,
    input  wire                     sda_in
);

    import eeprom_pkg::*;

    logic         xact_valid;
    eeprom_xact_t xact;
    xact_status_t status;
    logic         cmd_valid;
    bus_cmd_t     cmd;
    logic         cmd_ready;
    logic         step_done;
    bus_rsp_t     rsp;

    eeprom_apb_regs i_regs
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .xact_valid (xact_valid),
        .xact       (xact),
        .status     (status)
    );

    eeprom_sequencer i_seq
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .xact_valid (xact_valid),
        .xact       (xact),
        .status     (status),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .step_done  (step_done),
        .rsp        (rsp)
    );

    i2c_bit_engine i_engine
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .step_done  (step_done),
        .rsp        (rsp),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda_in)
    );

endmodule

`default_nettype wire

//--- src/eeprom_pkg.sv
`default_nettype none
`include "eeprom_params.svh"

package eeprom_pkg;

    // one host transaction
    typedef struct packed
    {
        logic                      rw;     // 1 = read
        logic [`EEPROM_ADDR_W-1:0] addr;
        logic [7:0]                wdata;
    } eeprom_xact_t;

    // device select byte as sent on the wire
    typedef struct packed
    {
        logic [3:0] dev_type;
        logic [2:0] block;   // byte address bits 10:8
        logic       rw;
    } sel_byte_t;

    typedef union packed
    {
        logic [7:0] raw;
        sel_byte_t  sel;
    } eeprom_byte_u;

    typedef enum logic [1:0]
    {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } bus_op_e;

    typedef struct packed
    {
        bus_op_e      op;
        eeprom_byte_u data;
        logic         master_nack;  // ack level driven after OP_READ
    } bus_cmd_t;

    typedef struct packed
    {
        logic [7:0] rdata;
        logic       slave_nack;  // ack bit seen after OP_WRITE
    } bus_rsp_t;

    typedef struct packed
    {
        logic       busy;
        logic       done;
        logic       nack;
        logic [7:0] rdata;
    } xact_status_t;

endpackage

`default_nettype wire

//--- src/eeprom_sequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_params.svh"

module eeprom_sequencer
(
    input  wire                            CLK,
    input  wire                            RESET,
    input  wire                            xact_valid,
    input  wire eeprom_pkg::eeprom_xact_t  xact,
    output eeprom_pkg::xact_status_t       status,
    output logic                           cmd_valid,
    output eeprom_pkg::bus_cmd_t           cmd,
    input  wire                            cmd_ready,
    input  wire                            step_done,
    input  wire eeprom_pkg::bus_rsp_t      rsp
);

    import eeprom_pkg::*;

    // one-hot bus phases
    typedef enum logic [9:0]
    {
        s_idle    = 10'b00_0000_0001,
        s_start   = 10'b00_0000_0010,
        s_ctrl_wr = 10'b00_0000_0100,
        s_addr    = 10'b00_0000_1000,
        s_data    = 10'b00_0001_0000,
        s_restart = 10'b00_0010_0000,
        s_ctrl_rd = 10'b00_0100_0000,
        s_data_rd = 10'b00_1000_0000,
        s_stop    = 10'b01_0000_0000,
        s_finish  = 10'b10_0000_0000
    } phase_e;

    phase_e       state;
    phase_e       state_nxt;
    eeprom_xact_t xact_q;
    eeprom_byte_u sel_byte;
    logic         byte_nack;
    logic         done_q;
    logic         nack_q;
    logic [7:0]   rdata_q;

    assign byte_nack = cmd.op == OP_WRITE && rsp.slave_nack;

    always_comb
    begin
        case (state)
            s_start:   state_nxt = s_ctrl_wr;
            s_ctrl_wr: state_nxt = s_addr;
            s_addr:    state_nxt = xact_q.rw ? s_restart : s_data;
            s_data:    state_nxt = s_stop;
            s_restart: state_nxt = s_ctrl_rd;
            s_ctrl_rd: state_nxt = s_data_rd;
            s_data_rd: state_nxt = s_stop;
            s_stop:    state_nxt = s_finish;
            default:   state_nxt = s_idle;
        endcase
        if (byte_nack)
            state_nxt = s_stop;  // device refused, release the bus
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= s_idle;
            cmd_valid <= 1'b0;
            done_q    <= 1'b0;
            nack_q    <= 1'b0;
            rdata_q   <= 8'h00;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                cmd_valid <= 1'b0;
            case (state)
                s_idle:
                begin
                    if (xact_valid)
                    begin
                        state     <= s_start;
                        cmd_valid <= 1'b1;
                        done_q    <= 1'b0;
                        nack_q    <= 1'b0;
                    end
                end
                s_finish:
                begin
                    state  <= s_idle;
                    done_q <= 1'b1;
                end
                default:
                begin
                    if (step_done)
                    begin
                        state     <= state_nxt;
                        cmd_valid <= state_nxt != s_finish;
                        if (byte_nack)
                            nack_q <= 1'b1;
                        if (state == s_data_rd)
                            rdata_q <= rsp.rdata;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == s_idle && xact_valid)
            xact_q <= xact;
    end

    always_comb
    begin
        sel_byte.sel.dev_type = 4'b1010;
        sel_byte.sel.block    = xact_q.addr[`EEPROM_ADDR_W-1:8];
        sel_byte.sel.rw       = state == s_ctrl_rd;
    end

    always_comb
    begin
        cmd.op          = OP_STOP;
        cmd.data.raw    = 8'h00;
        cmd.master_nack = 1'b1;  // single byte read ends with nack
        case (state)
            s_start, s_restart:
                cmd.op = OP_START;
            s_ctrl_wr, s_ctrl_rd:
            begin
                cmd.op   = OP_WRITE;
                cmd.data = sel_byte;
            end
            s_addr:
            begin
                cmd.op       = OP_WRITE;
                cmd.data.raw = xact_q.addr[7:0];
            end
            s_data:
            begin
                cmd.op       = OP_WRITE;
                cmd.data.raw = xact_q.wdata;
            end
            s_data_rd:
                cmd.op = OP_READ;
            default:
                cmd.op = OP_STOP;
        endcase
    end

    assign status.busy  = state != s_idle;
    assign status.done  = done_q;
    assign status.nack  = nack_q;
    assign status.rdata = rdata_q;

endmodule

`default_nettype wire

//--- src/i2c_bit_engine.sv
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_params.svh"

module i2c_bit_engine
(
    input  wire                         CLK,
    input  wire                         RESET,
    input  wire                         cmd_valid,
    input  wire eeprom_pkg::bus_cmd_t   cmd,
    output logic                        cmd_ready,
    output logic                        step_done,
    output eeprom_pkg::bus_rsp_t        rsp,
    output logic                        scl,
    output logic                        sda_oe,
    input  wire                         sda_in
);

    import eeprom_pkg::*;

    localparam int qcnt_w = $clog2(`SCL_QDIV);
    localparam logic [qcnt_w-1:0] qcnt_last = qcnt_w'(`SCL_QDIV - 1);

    logic              busy;
    logic [qcnt_w-1:0] qcnt;
    logic [1:0]        phase;   // 0 low, 1 rise, 2 high, 3 low
    logic [3:0]        bitcnt;  // 8 is the ack slot
    logic              tick;
    logic              last_bit;
    bus_op_e           op_q;
    logic [7:0]        shreg;
    logic              mnack_q;
    logic              ack_q;
    logic              scl_lvl;
    logic              oe_lvl;

    assign tick      = qcnt == qcnt_last;
    assign last_bit  = op_q == OP_START || op_q == OP_STOP || bitcnt == 4'd8;
    assign cmd_ready = !busy;

    always_comb
    begin
        scl_lvl = phase == 2'd1 || phase == 2'd2;
        oe_lvl  = 1'b0;
        case (op_q)
            OP_START:
                oe_lvl = phase[1];  // sda falls while scl high
            OP_STOP:
            begin
                scl_lvl = phase != 2'd0;
                oe_lvl  = !phase[1];  // sda rises while scl high
            end
            OP_WRITE:
                oe_lvl = bitcnt == 4'd8 ? 1'b0 : !shreg[7];
            OP_READ:
                oe_lvl = bitcnt == 4'd8 ? !mnack_q : 1'b0;
            default:
                oe_lvl = 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy      <= 1'b0;
            step_done <= 1'b0;
            qcnt      <= '0;
            phase     <= 2'd0;
            bitcnt    <= 4'd0;
            scl       <= 1'b1;  // bus released
            sda_oe    <= 1'b0;
        end
        else
        begin
            step_done <= 1'b0;
            if (!busy)
            begin
                if (cmd_valid)
                begin
                    busy   <= 1'b1;
                    qcnt   <= '0;
                    phase  <= 2'd0;
                    bitcnt <= 4'd0;
                end
            end
            else
            begin
                scl    <= scl_lvl;
                sda_oe <= oe_lvl;
                qcnt   <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                begin
                    phase <= phase + 2'd1;
                    if (phase == 2'd3)
                    begin
                        bitcnt <= bitcnt + 4'd1;
                        if (last_bit)
                        begin
                            busy      <= 1'b0;
                            step_done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy && cmd_valid)
        begin
            op_q    <= cmd.op;
            shreg   <= cmd.data.raw;
            mnack_q <= cmd.master_nack;
        end
        else if (busy && tick)
        begin
            // sample at the end of the rising quarter
            if (op_q == OP_READ && phase == 2'd1 && bitcnt < 4'd8)
                shreg <= {shreg[6:0], sda_in};
            if (op_q == OP_WRITE && phase == 2'd1 && bitcnt == 4'd8)
                ack_q <= sda_in;
            if (op_q == OP_WRITE && phase == 2'd3)
                shreg <= {shreg[6:0], 1'b0};  // msb first
        end
    end

    assign rsp.rdata      = shreg;
    assign rsp.slave_nack = ack_q;

endmodule

`default_nettype wire

//--- tests/eeprom_model.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_model
(
    input  wire  CLK,
    input  wire  scl,
    input  wire  sda,
    input  wire  force_nack,
    output logic sda_pull
);

    localparam logic [2:0] m_idle     = 3'd0;
    localparam logic [2:0] m_ctrl     = 3'd1;
    localparam logic [2:0] m_addr     = 3'd2;
    localparam logic [2:0] m_data     = 3'd3;
    localparam logic [2:0] m_tx_start = 3'd4;
    localparam logic [2:0] m_tx       = 3'd5;

    logic [7:0] mem [0:2047];
    logic       scl_q = 1'b1;
    logic       sda_q = 1'b1;
    logic [3:0] bitcnt = 4'd0;  // counts rising scl edges in a byte
    logic [2:0] mode = 3'd0;
    logic [7:0] shreg = 8'h00;
    logic [7:0] txbyte = 8'h00;
    logic [7:0] ptr = 8'h00;
    logic [2:0] block = 3'd0;

    initial
    begin
        sda_pull = 1'b0;
        for (int a = 0; a < 2048; a++)
            mem[a] = a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (scl && scl_q && sda_q && !sda)
        begin
            bitcnt   <= 4'd0;  // start or repeated start
            mode     <= m_ctrl;
            sda_pull <= 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            mode     <= m_idle;
            sda_pull <= 1'b0;
        end
        else if (scl && !scl_q)
        begin
            if (bitcnt < 4'd8)
                shreg <= {shreg[6:0], sda};
            if (bitcnt < 4'd9)
                bitcnt <= bitcnt + 4'd1;
        end
        else if (!scl && scl_q)
        begin
            if (bitcnt == 4'd8)
            begin
                case (mode)
                    m_ctrl:
                    begin
                        if (shreg[7:4] == 4'b1010 && !force_nack)
                        begin
                            sda_pull <= 1'b1;
                            block    <= shreg[3:1];
                            txbyte   <= mem[{shreg[3:1], ptr}];
                            mode     <= shreg[0] ? m_tx_start : m_addr;
                        end
                        else
                            mode <= m_idle;  // left unacked
                    end
                    m_addr:
                    begin
                        ptr      <= shreg;
                        sda_pull <= 1'b1;
                        mode     <= m_data;
                    end
                    m_data:
                    begin
                        mem[{block, ptr}] <= shreg;
                        sda_pull          <= 1'b1;
                        mode              <= m_idle;
                    end
                    m_tx:
                        sda_pull <= 1'b0;  // master acks here
                    default:
                        sda_pull <= 1'b0;
                endcase
            end
            else if (bitcnt == 4'd9)
            begin
                bitcnt   <= 4'd0;
                sda_pull <= mode == m_tx_start ? !txbyte[7] : 1'b0;
                if (mode == m_tx_start)
                    mode <= m_tx;
                else if (mode == m_tx)
                    mode <= m_idle;
            end
            else if (mode == m_tx && bitcnt != 4'd0)
                sda_pull <= !txbyte[3'(4'd7 - bitcnt)];
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_eeprom_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "eeprom_params.svh"

module tb_eeprom_ctrl;

    import apb_pkg::*;
    import eeprom_pkg::*;

    typedef struct packed
    {
        logic        rw;
        logic [10:0] addr;
        logic [7:0]  data;
        logic        exp_nack;
    } test_entry_t;

    localparam int num_tests = 20;
    localparam int max_cycles = num_tests * (39 * 4 * `SCL_QDIV + 50);

    logic        CLK = 1'b0;
    logic        RESET = 1'b1;
    apb_req_t    apb_req = '0;
    apb_rsp_t    apb_rsp;
    logic        scl;
    logic        sda_oe;
    logic        sda_pull;
    logic        force_nack = 1'b0;
    wire         sda;
    test_entry_t table_q [num_tests];
    logic [7:0]  shadow [0:2047];
    int          errors = 0;
    int          failed = 0;
    int          cycles = 0;

    assign sda = !(sda_oe || sda_pull);  // open drain bus

    eeprom_ctrl_top i_dut
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda)
    );

    eeprom_model i_model
    (
        .CLK        (CLK),
        .scl        (scl),
        .sda        (sda),
        .force_nack (force_nack),
        .sda_pull   (sda_pull)
    );

    always #50 CLK = !CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("timeout: transaction did not finish within %0d cycles", max_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic test_entry_t make_entry(input logic rw, input logic [10:0] addr,
                                               input logic [7:0] data, input logic nack);
        test_entry_t e;
        e.rw       = rw;
        e.addr     = addr;
        e.data     = data;
        e.exp_nack = nack;
        return e;
    endfunction

    function automatic apb_rsp_t make_rsp(input logic [31:0] d, input logic err);
        apb_rsp_t r;
        r.prdata  = d;
        r.pready  = 1'b1;
        r.pslverr = err;
        return r;
    endfunction

    task automatic check_byte(input string name, input eeprom_byte_u got, input eeprom_byte_u exp);
        if (got !== exp)
        begin
            $display("** Error: %s got %h expected %h", name, got.raw, exp.raw);
            errors++;
        end
    endtask

    task automatic check_status(input xact_status_t got, input xact_status_t exp);
        if (got !== exp)
        begin
            $display("** Error: status got busy %h done %h nack %h rdata %h, expected %h %h %h %h",
                     got.busy, got.done, got.nack, got.rdata,
                     exp.busy, exp.done, exp.nack, exp.rdata);
            errors++;
        end
    endtask

    task automatic check_rsp(input string name, input apb_rsp_t got, input apb_rsp_t exp);
        if (got !== exp)
        begin
            $display("** Error: %s got prdata %h pslverr %h, expected %h %h",
                     name, got.prdata, got.pslverr, exp.prdata, exp.pslverr);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // response sampled in the middle of the access phase
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output apb_rsp_t rsp);
        apb_req_t req;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = wr;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(posedge CLK);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge CLK);
        apb_req <= req;
        @(negedge CLK);
        rsp = apb_rsp;
        @(posedge CLK);
        apb_req <= '0;
    endtask

    task automatic wait_done(output xact_status_t st);
        apb_rsp_t rsp;
        logic     finished;
        finished = 1'b0;
        while (!finished)
        begin
            apb_access(1'b0, 4'hC, 32'h0, rsp);
            finished = !rsp.prdata[0];
        end
        st.busy = rsp.prdata[0];
        st.done = rsp.prdata[1];
        st.nack = rsp.prdata[2];
        apb_access(1'b0, 4'h8, 32'h0, rsp);
        st.rdata = rsp.prdata[7:0];
    endtask

    task automatic build_table();
        logic [31:0] seed;
        logic [10:0] a;
        seed = 32'h2116;
        table_q[0] = make_entry(1'b0, 11'h000, 8'h3C, 1'b0);
        table_q[1] = make_entry(1'b0, 11'h7FF, 8'hC3, 1'b0);
        table_q[2] = make_entry(1'b1, 11'h000, 8'h00, 1'b0);
        table_q[3] = make_entry(1'b1, 11'h7FF, 8'h00, 1'b0);
        for (int i = 0; i < 6; i++)
        begin
            seed = xorshift(seed);
            a = {3'(i + 1), seed[7:0]};  // a different block each time
            table_q[4 + i]  = make_entry(1'b0, a, seed[23:16], 1'b0);
            table_q[10 + i] = make_entry(1'b1, a, 8'h00, 1'b0);
        end
        table_q[16] = make_entry(1'b0, table_q[4].addr, 8'hA5, 1'b1);
        table_q[17] = make_entry(1'b1, table_q[4].addr, 8'h00, 1'b0);
        table_q[18] = make_entry(1'b1, 11'h123, 8'h00, 1'b1);
        table_q[19] = make_entry(1'b1, 11'h123, 8'h00, 1'b0);
    endtask

    initial
    begin
        apb_rsp_t     rsp;
        xact_status_t st;
        xact_status_t exp;
        test_entry_t  e;
        logic [7:0]   exp_rdata;
        int           err0;

        for (int a = 0; a < 2048; a++)
            shadow[a] = a[7:0] ^ {a[10:8], a[10:8], a[10:9]};
        build_table();
        exp_rdata = 8'h00;
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;

        err0 = errors;
        @(negedge CLK);
        check_bit("scl", scl, 1'b1);
        check_bit("sda_oe", sda_oe, 1'b0);
        apb_access(1'b0, 4'hC, 32'h0, rsp);
        check_rsp("STATUS", rsp, make_rsp(32'h0, 1'b0));
        apb_access(1'b1, 4'h4, 32'h0000_005C, rsp);
        apb_access(1'b0, 4'h4, 32'h0, rsp);
        check_rsp("WDATA", rsp, make_rsp(32'h5C, 1'b0));
        apb_access(1'b0, 4'h6, 32'h0, rsp);
        check_rsp("unmapped", rsp, make_rsp(32'h0, 1'b0));
        if (errors != err0)
            failed++;
        $display("test reset and registers: %s", errors == err0 ? "ok" : "failed");

        for (int i = 0; i < num_tests; i++)
        begin
            e = table_q[i];
            err0 = errors;
            @(posedge CLK);
            force_nack <= e.exp_nack;
            apb_access(1'b1, 4'h4, {24'h0, e.data}, rsp);
            apb_access(1'b1, 4'h0, {13'h0, e.addr, 7'h0, e.rw}, rsp);
            check_rsp("CMD", rsp, make_rsp(32'h0, 1'b0));
            if (i == 2)
            begin
                apb_access(1'b1, 4'h0, {13'h0, 11'h555, 8'h00}, rsp);
                check_rsp("CMD while busy", rsp, make_rsp(32'h0, 1'b1));
            end
            wait_done(st);
            if (!e.rw && !e.exp_nack)
                shadow[e.addr] = e.data;
            if (e.rw && !e.exp_nack)
                exp_rdata = shadow[e.addr];
            exp.busy  = 1'b0;
            exp.done  = 1'b1;
            exp.nack  = e.exp_nack;
            exp.rdata = exp_rdata;
            check_status(st, exp);
            check_byte("model memory", i_model.mem[e.addr], shadow[e.addr]);
            @(negedge CLK);
            check_bit("scl", scl, 1'b1);
            check_bit("sda_oe", sda_oe, 1'b0);
            if (errors != err0)
                failed++;
            $display("test %0d: %s addr %h data %h nack %0d: %s", i, e.rw ? "read" : "write",
                     e.addr, e.rw ? exp_rdata : e.data, e.exp_nack,
                     errors == err0 ? "ok" : "failed");
        end

        $display("tests %0d, failed %0d, errors %0d", num_tests + 1, failed, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
